/* hdl/clint_params.svh */
`ifndef CLINT_PARAMS_SVH
`define CLINT_PARAMS_SVH

// ------------------------------------------------
// CLINT address map
// ------------------------------------------------

// Base of the register window
`define CLINT_BASE          32'h0200_0000

// Register offsets from the base
`define CLINT_MTIME_LO      32'h0000_0000
`define CLINT_MTIME_HI      32'h0000_0004
`define CLINT_MTIMECMP_LO   32'h0000_0008
`define CLINT_MTIMECMP_HI   32'h0000_000C
`define CLINT_MSIP          32'h0000_0010

// AXI response codes
`define CLINT_RESP_OKAY     2'b00
`define CLINT_RESP_SLVERR   2'b10
`define CLINT_RESP_DECERR   2'b11

`endif

/* hdl/clint_pkg.sv */
package clint_pkg;

    // ------------------------------------------------
    // AXI4 channel payloads
    // ------------------------------------------------

    // Read address
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    // Write address, same layout as read address
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_aw_t;

    // Write data beat
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    // Read response beat
    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic [3:0]  id;
        logic        last;
    } axi_r_t;

    // Write response
    typedef struct packed {
        logic [1:0] resp;
        logic [3:0] id;
    } axi_b_t;

    // ------------------------------------------------
    // Register access
    // ------------------------------------------------

    // Target of one access, sel_none for unmapped
    typedef enum logic [2:0] {
        sel_mtime_lo,
        sel_mtime_hi,
        sel_mtimecmp_lo,
        sel_mtimecmp_hi,
        sel_msip,
        sel_none
    } reg_sel_e;

    // One strobed register write
    typedef struct packed {
        reg_sel_e    sel;
        logic [31:0] data;
        logic [3:0]  strb;
    } reg_wr_t;

endpackage

/* hdl/mtime_counter.sv */
`timescale 1ns/1ps

module mtime_counter (
    input  logic                clock,
    input  logic                reset,
    input  clint_pkg::reg_wr_t  time_wr,
    input  logic                time_wr_en,
    output logic [63:0]         mtime,
    output logic [63:0]         mtimecmp,
    output logic                mtip
);
    import clint_pkg::*;

    logic mtime_load;

    // Byte-wise merge of new data into a 32-bit half
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[i*8 +: 8] = new_val[i*8 +: 8];
        end
        return res;
    endfunction

    // A load to either half of mtime replaces the increment
    assign mtime_load = time_wr_en &&
                        (time_wr.sel == sel_mtime_lo || time_wr.sel == sel_mtime_hi);

    // Free-running counter, no carry into the high half on a low load
    always_ff @(posedge clock) begin
        if (reset) begin
            mtime <= '0;
        end else if (mtime_load && time_wr.sel == sel_mtime_lo) begin
            mtime[31:0] <= merge_bytes(mtime[31:0], time_wr.data, time_wr.strb);
        end else if (mtime_load) begin
            mtime[63:32] <= merge_bytes(mtime[63:32], time_wr.data, time_wr.strb);
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // Compare register, all ones keeps mtip quiet out of reset
    always_ff @(posedge clock) begin
        if (reset) begin
            mtimecmp <= '1;
        end else if (time_wr_en && time_wr.sel == sel_mtimecmp_lo) begin
            mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], time_wr.data, time_wr.strb);
        end else if (time_wr_en && time_wr.sel == sel_mtimecmp_hi) begin
            mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], time_wr.data, time_wr.strb);
        end
    end

    // Registered compare, one cycle behind the counter
    always_ff @(posedge clock) begin
        if (reset) mtip <= 1'b0;
        else       mtip <= (mtime >= mtimecmp);
    end

    // Counter steps by one whenever software leaves it alone
    a_mtime_step: assert property (@(posedge clock) disable iff (reset)
        !mtime_load |=> mtime == $past(mtime) + 64'd1);

endmodule

/* hdl/clint_regs.sv */
`timescale 1ns/1ps

module clint_regs (
    input  logic                 clock,
    input  logic                 reset,
    // Read port from the FSM
    input  clint_pkg::reg_sel_e  rd_sel,
    output logic [31:0]          rd_data,
    output logic                 rd_hit,
    // Write port from the FSM
    input  clint_pkg::reg_wr_t   wr,
    input  logic                 wr_en,
    // Timer side
    output clint_pkg::reg_wr_t   time_wr,
    output logic                 time_wr_en,
    input  logic [63:0]          mtime,
    input  logic [63:0]          mtimecmp,
    // Software interrupt
    output logic                 msip
);
    import clint_pkg::*;

    logic hit_timer;
    logic hit_msip;

    // ------------------------------------------------
    // Select decode
    // ------------------------------------------------

    // Timer registers live in mtime_counter
    assign hit_timer = (wr.sel == sel_mtime_lo)    || (wr.sel == sel_mtime_hi) ||
                       (wr.sel == sel_mtimecmp_lo) || (wr.sel == sel_mtimecmp_hi);
    assign hit_msip  = (wr.sel == sel_msip);

    // Anything but sel_none is mapped
    assign rd_hit = (rd_sel != sel_none);

    // ------------------------------------------------
    // msip register
    // ------------------------------------------------

    // Only bit 0 exists, byte lane 0 strobe
    always_ff @(posedge clock) begin
        if (reset) begin
            msip <= 1'b0;
        end else if (wr_en && hit_msip && wr.strb[0]) begin
            msip <= wr.data[0];
        end
    end

    // Timer writes pass on unchanged, qualified by decode
    assign time_wr    = wr;
    assign time_wr_en = wr_en && hit_timer;

    // ------------------------------------------------
    // Read multiplexer
    // ------------------------------------------------

    always_comb begin
        case (rd_sel)
            sel_mtime_lo:    rd_data = mtime[31:0];
            sel_mtime_hi:    rd_data = mtime[63:32];
            sel_mtimecmp_lo: rd_data = mtimecmp[31:0];
            sel_mtimecmp_hi: rd_data = mtimecmp[63:32];
            // Upper msip bits read as zero
            sel_msip:        rd_data = {31'd0, msip};
            default:         rd_data = 32'd0;
        endcase
    end

endmodule

/* hdl/resp_slot.sv */
`timescale 1ns/1ps

module resp_slot #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    // Load side, from the FSM
    input  logic     load,
    input  payload_t in_payload,
    // AXI response side
    output payload_t out_payload,
    output logic     out_valid,
    input  logic     out_ready
);

    // Payload held until taken, no reset needed
    always_ff @(posedge clock) begin
        if (load) out_payload <= in_payload;
    end

    // Full flag doubles as valid
    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_valid && out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Never overwrite a pending response
    a_no_overwrite: assert property (@(posedge clock) disable iff (reset)
        load |-> !out_valid);

endmodule

/* hdl/clint_axi_fsm.sv */
`timescale 1ns/1ps
`include "clint_params.svh"

module clint_axi_fsm (
    input  logic                 clock,
    input  logic                 reset,
    // Request channels
    input  clint_pkg::axi_ar_t   ar,
    input  logic                 ar_valid,
    output logic                 ar_ready,
    input  clint_pkg::axi_aw_t   aw,
    input  logic                 aw_valid,
    output logic                 aw_ready,
    input  clint_pkg::axi_w_t    w,
    input  logic                 w_valid,
    output logic                 w_ready,
    // Slot status
    input  logic                 r_full,
    input  logic                 b_full,
    // Register access
    output clint_pkg::reg_sel_e  rd_sel,
    input  logic [31:0]          rd_data,
    input  logic                 rd_hit,
    output clint_pkg::reg_wr_t   wr,
    output logic                 wr_en,
    // Response slot loads
    output logic                 r_load,
    output clint_pkg::axi_r_t    r_payload,
    output logic                 b_load,
    output clint_pkg::axi_b_t    b_payload
);
    import clint_pkg::*;

    typedef enum logic [1:0] {reset_wait, serve, hold} state_e;

    state_e state;
    logic   base_ready;
    logic   ar_hs;
    logic   wr_hs;
    logic   rd_len_bad;
    logic   wr_len_bad;

    // Full-address decode, misaligned hits fall to sel_none
    function automatic reg_sel_e decode_addr(input logic [31:0] addr);
        case (addr)
            `CLINT_BASE + `CLINT_MTIME_LO:    return sel_mtime_lo;
            `CLINT_BASE + `CLINT_MTIME_HI:    return sel_mtime_hi;
            `CLINT_BASE + `CLINT_MTIMECMP_LO: return sel_mtimecmp_lo;
            `CLINT_BASE + `CLINT_MTIMECMP_HI: return sel_mtimecmp_hi;
            `CLINT_BASE + `CLINT_MSIP:        return sel_msip;
            default:                          return sel_none;
        endcase
    endfunction

    // Length errors beat address errors
    function automatic logic [1:0] resp_code(input logic len_bad, input logic hit);
        if (len_bad)  return `CLINT_RESP_SLVERR;
        else if (!hit) return `CLINT_RESP_DECERR;
        else          return `CLINT_RESP_OKAY;
    endfunction

    // ------------------------------------------------
    // State register
    // ------------------------------------------------

    // Hold parks the FSM while both response paths are blocked
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= reset_wait;
        end else begin
            case (state)
                reset_wait: state <= serve;
                serve:      if (r_full && b_full) state <= hold;
                hold:       if (!(r_full && b_full)) state <= serve;
                default:    state <= reset_wait;
            endcase
        end
    end

    // ------------------------------------------------
    // Handshakes, read first
    // ------------------------------------------------

    assign base_ready = (state == serve);
    assign ar_ready   = base_ready && !r_full;
    assign ar_hs      = ar_valid && ar_ready;

    // AW and W go together, each ready waits on the other valid
    assign aw_ready = base_ready && !b_full && !ar_hs && w_valid;
    assign w_ready  = base_ready && !b_full && !ar_hs && aw_valid;
    assign wr_hs    = aw_valid && aw_ready;

    // Single beat only
    assign rd_len_bad = (ar.len != 8'd0);
    assign wr_len_bad = (aw.len != 8'd0) || !w.last;

    // Shared decode, the write address when no read is taken
    assign rd_sel = ar_hs ? decode_addr(ar.addr) : decode_addr(aw.addr);

    // Register write on a clean write beat
    assign wr.sel  = rd_sel;
    assign wr.data = w.data;
    assign wr.strb = w.strb;
    assign wr_en   = wr_hs && !wr_len_bad && rd_hit;

    // ------------------------------------------------
    // Response forming
    // ------------------------------------------------

    assign r_load         = ar_hs;
    assign r_payload.data = (!rd_len_bad && rd_hit) ? rd_data : 32'd0;
    assign r_payload.resp = resp_code(rd_len_bad, rd_hit);
    assign r_payload.id   = ar.id;
    assign r_payload.last = 1'b1;

    assign b_load         = wr_hs;
    assign b_payload.resp = resp_code(wr_len_bad, rd_hit);
    assign b_payload.id   = aw.id;

    // A pending read request stays put until accepted
    a_ar_held: assert property (@(posedge clock) disable iff (reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar));

    // A pending write pair stays put until accepted
    a_wr_held: assert property (@(posedge clock) disable iff (reset)
        aw_valid && w_valid && !aw_ready |=> aw_valid && w_valid && $stable(aw) && $stable(w));

endmodule

/* hdl/clint_top.sv */
`timescale 1ns/1ps

module clint_top (
    input  logic                clock,
    input  logic                reset,
    // Read address
    input  clint_pkg::axi_ar_t  ar,
    input  logic                ar_valid,
    output logic                ar_ready,
    // Write address
    input  clint_pkg::axi_aw_t  aw,
    input  logic                aw_valid,
    output logic                aw_ready,
    // Write data
    input  clint_pkg::axi_w_t   w,
    input  logic                w_valid,
    output logic                w_ready,
    // Read response
    output clint_pkg::axi_r_t   r,
    output logic                r_valid,
    input  logic                r_ready,
    // Write response
    output clint_pkg::axi_b_t   b,
    output logic                b_valid,
    input  logic                b_ready,
    // Interrupts
    output logic                mtip,
    output logic                msip
);
    import clint_pkg::*;

    reg_sel_e    rd_sel;
    logic [31:0] rd_data;
    logic        rd_hit;
    reg_wr_t     wr;
    logic        wr_en;
    reg_wr_t     time_wr;
    logic        time_wr_en;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        r_load;
    axi_r_t      r_payload;
    logic        b_load;
    axi_b_t      b_payload;

    // ------------------------------------------------
    // Request handling
    // ------------------------------------------------

    clint_axi_fsm clint_axi_fsm_i (
        .clock     (clock),
        .reset     (reset),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .r_full    (r_valid),
        .b_full    (b_valid),
        .rd_sel    (rd_sel),
        .rd_data   (rd_data),
        .rd_hit    (rd_hit),
        .wr        (wr),
        .wr_en     (wr_en),
        .r_load    (r_load),
        .r_payload (r_payload),
        .b_load    (b_load),
        .b_payload (b_payload)
    );

    // Register file and timer
    clint_regs clint_regs_i (
        .clock      (clock),
        .reset      (reset),
        .rd_sel     (rd_sel),
        .rd_data    (rd_data),
        .rd_hit     (rd_hit),
        .wr         (wr),
        .wr_en      (wr_en),
        .time_wr    (time_wr),
        .time_wr_en (time_wr_en),
        .mtime      (mtime),
        .mtimecmp   (mtimecmp),
        .msip       (msip)
    );

    mtime_counter mtime_counter_i (
        .clock      (clock),
        .reset      (reset),
        .time_wr    (time_wr),
        .time_wr_en (time_wr_en),
        .mtime      (mtime),
        .mtimecmp   (mtimecmp),
        .mtip       (mtip)
    );

    // ------------------------------------------------
    // Response slots, R and B
    // ------------------------------------------------

    resp_slot #(.payload_t(axi_r_t)) r_slot_i (
        .clock       (clock),
        .reset       (reset),
        .load        (r_load),
        .in_payload  (r_payload),
        .out_payload (r),
        .out_valid   (r_valid),
        .out_ready   (r_ready)
    );

    resp_slot #(.payload_t(axi_b_t)) b_slot_i (
        .clock       (clock),
        .reset       (reset),
        .load        (b_load),
        .in_payload  (b_payload),
        .out_payload (b),
        .out_valid   (b_valid),
        .out_ready   (b_ready)
    );

endmodule

/* bench/clint_tb.sv */
`timescale 1ns/1ps
`include "clint_params.svh"

module clint_tb;
    import clint_pkg::*;

    localparam int unsigned TIMEOUT    = 300;
    localparam int unsigned MAX_CYCLES = 100000;
    localparam logic [31:0] SEED       = 32'hf7c0;

    // Expected R beat, mtime data is checked by the test itself
    typedef struct packed {
        axi_r_t beat;
        logic   skip_data;
    } exp_r_t;

    logic    clock;
    logic    reset;
    axi_ar_t ar;
    logic    ar_valid;
    logic    ar_ready;
    axi_aw_t aw;
    logic    aw_valid;
    logic    aw_ready;
    axi_w_t  w;
    logic    w_valid;
    logic    w_ready;
    axi_r_t  r;
    logic    r_valid;
    logic    r_ready;
    axi_b_t  b;
    logic    b_valid;
    logic    b_ready;
    logic    mtip;
    logic    msip;

    // Shadow registers and scoreboard
    exp_r_t      exp_r_q[$];
    axi_b_t      exp_b_q[$];
    logic [63:0] sh_cmp;
    logic        sh_msip;
    string       test_name;
    int unsigned test_errors;
    int unsigned mark;
    int unsigned tests_run;
    int unsigned tests_failed;
    int unsigned check_errors = 0;
    int unsigned r_count = 0;
    int unsigned b_count = 0;
    int unsigned cycle = 0;
    logic        abort = 1'b0;
    exp_r_t      er;
    axi_b_t      eb;
    axi_r_t      r_seen;
    axi_b_t      b_seen;
    logic        r_hold = 1'b0;
    logic        b_hold = 1'b0;

    clint_top clint_top_i (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;

    // Run limiter, also ends the run after a stalled handshake
    initial begin : run_limit
        int unsigned n;
        n = 0;
        while (!abort && n < MAX_CYCLES) begin
            @(posedge clock);
            n++;
        end
        if (!abort) $display("Run stopped after %0d cycles without finishing", MAX_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    // Register number 0..4, or -1 off the map
    function automatic int reg_index(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - `CLINT_BASE;
        if (off[1:0] != 2'b00 || off > `CLINT_MSIP) return -1;
        return int'(off[4:2]);
    endfunction

    function automatic logic [31:0] reg_addr(input int idx);
        return `CLINT_BASE + 32'(idx) * 32'd4;
    endfunction

    function automatic axi_r_t ref_read(input logic [31:0] addr, input logic [7:0] len);
        axi_r_t beat;
        int     idx;
        idx = reg_index(addr);
        beat = '0;
        beat.last = 1'b1;
        if (len != 8'd0) beat.resp = `CLINT_RESP_SLVERR;
        else if (idx < 0) beat.resp = `CLINT_RESP_DECERR;
        else begin
            beat.resp = `CLINT_RESP_OKAY;
            case (idx)
                2: beat.data = sh_cmp[31:0];
                3: beat.data = sh_cmp[63:32];
                4: beat.data = {31'd0, sh_msip};
                default: beat.data = 32'd0;
            endcase
        end
        return beat;
    endfunction

    // Shadow update for one accepted write, returns the B code
    task automatic apply_write(input logic [31:0] addr, input logic [7:0] len,
                               input logic [31:0] data, input logic [3:0] strb,
                               output logic [1:0] resp);
        logic [31:0] m;
        int          idx;
        idx = reg_index(addr);
        m = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        if (len != 8'd0) resp = `CLINT_RESP_SLVERR;
        else if (idx < 0) resp = `CLINT_RESP_DECERR;
        else begin
            resp = `CLINT_RESP_OKAY;
            if (idx == 2) sh_cmp[31:0] = (sh_cmp[31:0] & ~m) | (data & m);
            else if (idx == 3) sh_cmp[63:32] = (sh_cmp[63:32] & ~m) | (data & m);
            else if (idx == 4 && strb[0]) sh_msip = data[0];
        end
    endtask

    // --------------------------------------------------
    // AXI drivers, all start and end 1 ns after an edge
    // --------------------------------------------------

    task automatic give_up(input string why);
        $display("Test %s: %s", test_name, why);
        abort = 1'b1;
        forever @(posedge clock);
    endtask

    task automatic send_read(input logic [31:0] addr, input logic [3:0] id,
                             input logic [7:0] len);
        int unsigned t;
        exp_r_t      e;
        ar = '{addr: addr, id: id, len: len, size: 3'd2, burst: 2'b01};
        ar_valid = 1'b1;
        t = 0;
        @(posedge clock);
        while (!ar_ready) begin
            t++;
            if (t > TIMEOUT) give_up("AR never accepted");
            @(posedge clock);
        end
        // Expected value is the register as of the AR cycle
        e.beat = ref_read(addr, len);
        e.beat.id = id;
        e.skip_data = (len == 8'd0) && (reg_index(addr) == 0 || reg_index(addr) == 1);
        exp_r_q.push_back(e);
        #1;
        ar_valid = 1'b0;
    endtask

    task automatic send_write(input logic [31:0] addr, input logic [3:0] id,
                              input logic [7:0] len, input logic [31:0] data,
                              input logic [3:0] strb);
        int unsigned t;
        axi_b_t      e;
        aw = '{addr: addr, id: id, len: len, size: 3'd2, burst: 2'b01};
        w = '{data: data, strb: strb, last: 1'b1};
        aw_valid = 1'b1;
        w_valid = 1'b1;
        t = 0;
        @(posedge clock);
        while (!(aw_ready && w_ready)) begin
            t++;
            if (t > TIMEOUT) give_up("AW and W never accepted");
            @(posedge clock);
        end
        apply_write(addr, len, data, strb, e.resp);
        e.id = id;
        exp_b_q.push_back(e);
        #1;
        aw_valid = 1'b0;
        w_valid = 1'b0;
    endtask

    // Random ready delay, then take one R or B beat
    task automatic take_resp(input logic is_read, output logic [31:0] data);
        int unsigned t;
        int unsigned d;
        d = $urandom_range(0, 5);
        repeat (d) begin
            @(posedge clock);
            #1;
        end
        if (is_read) r_ready = 1'b1;
        else b_ready = 1'b1;
        t = 0;
        @(posedge clock);
        while (is_read ? !r_valid : !b_valid) begin
            t++;
            if (t > TIMEOUT) give_up(is_read ? "no R response" : "no B response");
            @(posedge clock);
        end
        data = is_read ? r.data : 32'd0;
        #1;
        r_ready = 1'b0;
        b_ready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, input logic [3:0] id,
                            input logic [7:0] len, output logic [31:0] data);
        send_read(addr, id, len);
        take_resp(1'b1, data);
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [3:0] id,
                             input logic [7:0] len, input logic [31:0] data,
                             input logic [3:0] strb);
        logic [31:0] unused;
        send_write(addr, id, len, data, strb);
        take_resp(1'b0, unused);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        mark = test_errors + check_errors;
    endtask

    task automatic end_test();
        int unsigned n;
        n = test_errors + check_errors - mark;
        tests_run++;
        if (n != 0) tests_failed++;
        $display("test %s: %s, %0d errors", test_name, (n == 0) ? "ok" : "failed", n);
    endtask

    // --------------------------------------------------
    // Response checker
    // --------------------------------------------------

    always @(posedge clock) begin
        if (!reset) begin
            // Held beats must not move
            if (r_hold && r !== r_seen) begin
                $display("Test %s: R payload changed while waiting for r_ready", test_name);
                check_errors++;
            end
            if (b_hold && b !== b_seen) begin
                $display("Test %s: B payload changed while waiting for b_ready", test_name);
                check_errors++;
            end
            if (r_valid && r_ready) begin
                r_count++;
                if (exp_r_q.size() == 0) begin
                    $display("Test %s: R beat id %h with no read outstanding", test_name, r.id);
                    check_errors++;
                end else begin
                    er = exp_r_q.pop_front();
                    if ({r.id, r.resp, r.last} !== {er.beat.id, er.beat.resp, er.beat.last}) begin
                        $display("MISMATCH %s R id/resp/last: expected %h, actual %h", test_name,
                                 {er.beat.id, er.beat.resp, er.beat.last}, {r.id, r.resp, r.last});
                        check_errors++;
                    end
                    if (!er.skip_data && r.data !== er.beat.data) begin
                        $display("MISMATCH %s R data: expected %h, actual %h", test_name,
                                 er.beat.data, r.data);
                        check_errors++;
                    end
                end
            end
            if (b_valid && b_ready) begin
                b_count++;
                if (exp_b_q.size() == 0) begin
                    $display("Test %s: B beat id %h with no write outstanding", test_name, b.id);
                    check_errors++;
                end else begin
                    eb = exp_b_q.pop_front();
                    if (b !== eb) begin
                        $display("MISMATCH %s B id/resp: expected %h, actual %h", test_name,
                                 eb, b);
                        check_errors++;
                    end
                end
            end
            r_hold = r_valid && !r_ready;
            b_hold = b_valid && !b_ready;
            r_seen = r;
            b_seen = b;
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin : main
        int          idx;
        int unsigned t;
        int unsigned n;
        int unsigned t0;
        int unsigned r_goal;
        int unsigned b_goal;
        logic [31:0] rdata;
        logic [31:0] x_lo;
        logic [31:0] x_hi;
        logic [31:0] prev;
        logic        seen;

        void'($urandom(SEED));
        ar = '0;
        ar_valid = 1'b0;
        aw = '0;
        aw_valid = 1'b0;
        w = '0;
        w_valid = 1'b0;
        r_ready = 1'b0;
        b_ready = 1'b0;
        sh_cmp = '1;
        sh_msip = 1'b0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_name = "reset";
        reset = 1'b1;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        // Strobed writes to mtimecmp and msip, each read back
        start_test("strobed_rw");
        repeat (12) begin
            idx = $urandom_range(2, 4);
            axi_write(reg_addr(idx), 4'($urandom), 8'd0, $urandom, 4'($urandom_range(1, 15)));
            axi_read(reg_addr(idx), 4'($urandom), 8'd0, rdata);
        end
        for (idx = 2; idx <= 4; idx++) axi_read(reg_addr(idx), 4'(idx), 8'd0, rdata);
        end_test();

        // mtime load, then bounded and monotonic reads
        start_test("mtime_load");
        x_lo = $urandom_range(0, 32'h0FFF_FFFF);
        x_hi = $urandom_range(1, 32'h7FFF_FFFF);
        t0 = cycle;
        axi_write(reg_addr(0), 4'h1, 8'd0, x_lo, 4'hf);
        axi_write(reg_addr(1), 4'h2, 8'd0, x_hi, 4'hf);
        prev = x_lo;
        repeat (4) begin
            axi_read(reg_addr(0), 4'h3, 8'd0, rdata);
            if (rdata < prev || rdata > x_lo + (cycle - t0)) begin
                $display("Test %s: mtime low %h outside %h..%h or went back", test_name,
                         rdata, prev, x_lo + (cycle - t0));
                test_errors++;
            end
            prev = rdata;
        end
        axi_read(reg_addr(1), 4'h4, 8'd0, rdata);
        if (rdata !== x_hi) begin
            $display("MISMATCH %s mtime_hi: expected %h, actual %h", test_name, x_hi, rdata);
            test_errors++;
        end
        end_test();

        // Timer and software interrupt outputs
        start_test("interrupts");
        axi_write(reg_addr(3), 4'h5, 8'd0, 32'hFFFF_0000, 4'hf);
        axi_write(reg_addr(2), 4'h6, 8'd0, 32'd0, 4'hf);
        seen = 1'b0;
        repeat (40) begin
            @(posedge clock);
            seen = seen | mtip;
        end
        #1;
        if (seen) begin
            $display("Test %s: mtip went high with mtimecmp far ahead", test_name);
            test_errors++;
        end
        axi_read(reg_addr(0), 4'h7, 8'd0, rdata);
        axi_write(reg_addr(2), 4'h8, 8'd0, rdata + 32'd20, 4'hf);
        axi_write(reg_addr(3), 4'h9, 8'd0, x_hi, 4'hf);
        t = 0;
        while (!mtip && t < TIMEOUT) begin
            @(posedge clock);
            #1;
            t++;
        end
        if (!mtip) begin
            $display("Test %s: mtip did not rise within %0d cycles", test_name, TIMEOUT);
            test_errors++;
        end
        seen = 1'b0;
        repeat (30) begin
            @(posedge clock);
            seen = seen | !mtip;
        end
        #1;
        if (seen) begin
            $display("Test %s: mtip dropped while mtime was past mtimecmp", test_name);
            test_errors++;
        end
        axi_write(reg_addr(4), 4'hA, 8'd0, 32'd1, 4'h1);
        if (msip !== 1'b1) begin
            $display("MISMATCH %s msip: expected 1, actual %b", test_name, msip);
            test_errors++;
        end
        axi_write(reg_addr(4), 4'hB, 8'd0, 32'd0, 4'h1);
        if (msip !== 1'b0) begin
            $display("MISMATCH %s msip: expected 0, actual %b", test_name, msip);
            test_errors++;
        end
        end_test();

        // Decode and length errors leave registers alone
        start_test("error_responses");
        axi_read(`CLINT_BASE + 32'h20, 4'h1, 8'd0, rdata);
        axi_read(`CLINT_BASE + 32'h6, 4'h2, 8'd0, rdata);
        axi_read(reg_addr(2), 4'h3, 8'd3, rdata);
        axi_read(reg_addr(0), 4'h4, 8'd1, rdata);
        axi_write(reg_addr(2), 4'h5, 8'd2, $urandom, 4'hf);
        axi_write(reg_addr(4), 4'h6, 8'd1, 32'd1, 4'hf);
        axi_write(`CLINT_BASE + 32'h40, 4'h7, 8'd0, $urandom, 4'hf);
        for (idx = 2; idx <= 4; idx++) axi_read(reg_addr(idx), 4'(idx), 8'd0, rdata);
        end_test();

        // Reads and writes under random response back-pressure
        start_test("back_pressure");
        r_goal = r_count + 10;
        b_goal = b_count + 10;
        fork
            begin
                for (int i = 0; i < 10; i++) send_read(reg_addr($urandom_range(2, 4)), 4'(i), 8'd0);
            end
            begin
                for (int j = 0; j < 10; j++)
                    send_write(reg_addr($urandom_range(2, 4)), 4'(j), 8'd0, $urandom,
                               4'($urandom));
            end
            begin
                t = 0;
                while (r_count < r_goal || b_count < b_goal) begin
                    r_ready = ($urandom_range(0, 3) == 0);
                    b_ready = ($urandom_range(0, 3) == 0);
                    n = $urandom_range(1, 6);
                    repeat (n) begin
                        @(posedge clock);
                        #1;
                    end
                    t++;
                    if (t > TIMEOUT) give_up("responses missing under back-pressure");
                end
                r_ready = 1'b0;
                b_ready = 1'b0;
            end
        join
        if (exp_r_q.size() != 0 || exp_b_q.size() != 0 || r_count != r_goal ||
            b_count != b_goal) begin
            $display("Test %s: response count off, %0d R and %0d B still expected", test_name,
                     exp_r_q.size(), exp_b_q.size());
            test_errors++;
        end
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 test_errors + check_errors);
        if (tests_failed == 0 && test_errors + check_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+hdl
hdl/clint_pkg.sv
hdl/mtime_counter.sv
hdl/clint_regs.sv
hdl/resp_slot.sv
hdl/clint_axi_fsm.sv
hdl/clint_top.sv
bench/clint_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= clint_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)

.PHONY: all run check clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@grep -qx "TEST PASS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
